/* design/memcopy_pkg.sv */
// ========================================
// Shared types and constants of the memcopy DMA
// Imported by every RTL module of the design
// ========================================

package memcopy_pkg;

  // Data and address word
  typedef logic [31:0] word_t;

  // Word count of one transfer
  typedef logic [15:0] len_t;

  // Register byte offsets on the register bus
  typedef enum logic [7:0] {
    REG_SRC     = 8'h00,
    REG_DST     = 8'h04,
    REG_LEN     = 8'h08,
    REG_STATUS  = 8'h0C,
    REG_INTR_EN = 8'h10
  } reg_addr_e;

  // Engine FSM states, shared by the read and write engines
  typedef enum logic [1:0] {
    IDLE,
    RUN,
    DRAIN
  } engine_state_e;

  // Default depth of the data FIFO, in words
  localparam int unsigned FIFO_DEPTH_DEFAULT = 4;

  // Bit positions inside STATUS
  localparam int unsigned STATUS_IDLE_BIT = 0;
  localparam int unsigned STATUS_DONE_BIT = 1;

endpackage

/* design/memcopy_regs.sv */
// ========================================
// Register bus slave of the memcopy DMA
// Holds the transfer setup, status flags and the done interrupt
// ========================================

`timescale 1ns/1ps

module memcopy_regs
  import memcopy_pkg::*;
(
  input  logic  clk_i,
  input  logic  reset_i,
  input  logic  reg_valid_i,
  input  logic  reg_write_i,
  input  word_t reg_addr_i,
  input  word_t reg_wdata_i,
  output logic  reg_ready_o,
  output word_t reg_rdata_o,
  output logic  start_o,
  output word_t src_o,
  output word_t dst_o,
  output len_t  len_o,
  input  logic  xfer_done_i,
  output logic  done_intr_o
);

  logic  access;
  logic  start_ok;
  logic  status_rd;
  logic  busy_q;
  logic  done_q;
  word_t intr_en_q;
  word_t src_q;
  word_t dst_q;
  len_t  len_q;
  word_t status;
  word_t rdata_d;

  // First cycle of a request; the ready pulse follows one cycle later
  assign access    = reg_valid_i && !reg_ready_o;
  assign status_rd = access && !reg_write_i && (reg_addr_i == REG_STATUS);

  // Nonzero length written while idle kicks off a copy
  assign start_ok = access && reg_write_i && (reg_addr_i == REG_LEN) &&
                    !busy_q && (reg_wdata_i[15:0] != '0);

  always_comb begin
    status                  = '0;
    status[STATUS_IDLE_BIT] = !busy_q;
    status[STATUS_DONE_BIT] = done_q;
  end

  always_comb begin
    case (reg_addr_i)
      REG_SRC:     rdata_d = src_q;
      REG_DST:     rdata_d = dst_q;
      REG_LEN:     rdata_d = {16'h0000, len_q};
      REG_STATUS:  rdata_d = status;
      REG_INTR_EN: rdata_d = intr_en_q;
      default:     rdata_d = '0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      reg_ready_o <= 1'b0;
      start_o     <= 1'b0;
      busy_q      <= 1'b0;
      done_q      <= 1'b0;
      intr_en_q   <= '0;
    end else begin
      reg_ready_o <= access;
      start_o     <= start_ok;
      if (start_ok) begin
        busy_q <= 1'b1;
      end else if (xfer_done_i) begin
        busy_q <= 1'b0;
      end
      // A new done event wins over a clearing read
      done_q <= (done_q && !status_rd) || xfer_done_i;
      if (access && reg_write_i && (reg_addr_i == REG_INTR_EN)) begin
        intr_en_q <= reg_wdata_i;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (access && reg_write_i && (reg_addr_i == REG_SRC)) begin
      src_q <= reg_wdata_i;
    end
    if (access && reg_write_i && (reg_addr_i == REG_DST)) begin
      dst_q <= reg_wdata_i;
    end
    if (start_ok) begin
      len_q <= reg_wdata_i[15:0];
    end
    if (access) begin
      reg_rdata_o <= rdata_d;
    end
  end

  assign src_o       = src_q;
  assign dst_o       = dst_q;
  assign len_o       = len_q;
  assign done_intr_o = done_q && intr_en_q[0];

endmodule

/* design/obi_read_engine.sv */
// ========================================
// OBI read master of the memcopy DMA
// Fetches len words from src and pushes them into the FIFO
// ========================================

`timescale 1ns/1ps

module obi_read_engine
  import memcopy_pkg::*;
#(
  parameter int unsigned fifo_depth = FIFO_DEPTH_DEFAULT
) (
  input  logic                            clk_i,
  input  logic                            reset_i,
  input  logic                            start_i,
  input  word_t                           src_i,
  input  len_t                            len_i,
  input  logic [$clog2(fifo_depth+1)-1:0] free_count_i,
  output logic                            push_o,
  output word_t                           push_data_o,
  output logic                            rd_req_o,
  output word_t                           rd_addr_o,
  input  logic                            rd_gnt_i,
  input  logic                            rd_rvalid_i,
  input  word_t                           rd_rdata_i
);

  localparam int unsigned cnt_w = $clog2(fifo_depth + 1);

  engine_state_e    state_q;
  word_t            addr_q;
  len_t             left_q;
  logic [cnt_w-1:0] outstanding_q;
  logic [cnt_w-1:0] outstanding_d;
  logic             granted;

  // Only ask when the FIFO can hold every read already in flight plus this one
  assign rd_req_o  = (state_q == RUN) && (free_count_i > outstanding_q);
  assign rd_addr_o = addr_q;
  assign granted   = rd_req_o && rd_gnt_i;

  assign outstanding_d = outstanding_q + cnt_w'(granted) - cnt_w'(rd_rvalid_i);

  // Read data goes straight into the FIFO
  assign push_o      = rd_rvalid_i;
  assign push_data_o = rd_rdata_i;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q       <= IDLE;
      outstanding_q <= '0;
    end else begin
      outstanding_q <= outstanding_d;
      case (state_q)
        IDLE: begin
          if (start_i) begin
            state_q <= RUN;
          end
        end
        RUN: begin
          if (granted && (left_q == len_t'(1))) begin
            state_q <= DRAIN;
          end
        end
        DRAIN: begin
          if (outstanding_d == '0) begin
            state_q <= IDLE;
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (start_i && (state_q == IDLE)) begin
      addr_q <= src_i;
      left_q <= len_i;
    end else if (granted) begin
      addr_q <= addr_q + 32'd4;
      left_q <= left_q - len_t'(1);
    end
  end

endmodule

/* design/memcopy_fifo.sv */
// ========================================
// Data FIFO between the read and write engines
// First word falls through; free space is reported to the reader
// ========================================

`timescale 1ns/1ps

module memcopy_fifo
  import memcopy_pkg::*;
#(
  parameter int unsigned fifo_depth = FIFO_DEPTH_DEFAULT
) (
  input  logic                            clk_i,
  input  logic                            reset_i,
  input  logic                            push_i,
  input  word_t                           push_data_i,
  input  logic                            pop_i,
  output word_t                           pop_data_o,
  output logic                            not_empty_o,
  output logic [$clog2(fifo_depth+1)-1:0] free_count_o
);

  localparam int unsigned ptr_w = $clog2(fifo_depth);
  localparam int unsigned cnt_w = $clog2(fifo_depth + 1);

  word_t            mem [fifo_depth];
  logic [ptr_w-1:0] wr_ptr_q;
  logic [ptr_w-1:0] rd_ptr_q;
  logic [cnt_w-1:0] count_q;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= (wr_ptr_q == ptr_w'(fifo_depth - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop_i) begin
        rd_ptr_q <= (rd_ptr_q == ptr_w'(fifo_depth - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      count_q <= count_q + cnt_w'(push_i) - cnt_w'(pop_i);
    end
  end

  always_ff @(posedge clk_i) begin
    if (push_i) begin
      mem[wr_ptr_q] <= push_data_i;
    end
  end

  assign pop_data_o   = mem[rd_ptr_q];
  assign not_empty_o  = (count_q != '0);
  assign free_count_o = cnt_w'(fifo_depth) - count_q;

endmodule

/* design/obi_write_engine.sv */
// ========================================
// OBI write master of the memcopy DMA
// Drains the FIFO to dst and signals done on the last response
// ========================================

`timescale 1ns/1ps

module obi_write_engine
  import memcopy_pkg::*;
(
  input  logic       clk_i,
  input  logic       reset_i,
  input  logic       start_i,
  input  word_t      dst_i,
  input  len_t       len_i,
  input  logic       not_empty_i,
  input  word_t      pop_data_i,
  output logic       pop_o,
  output logic       wr_req_o,
  output word_t      wr_addr_o,
  output word_t      wr_wdata_o,
  output logic [3:0] wr_be_o,
  input  logic       wr_gnt_i,
  input  logic       wr_rvalid_i,
  output logic       xfer_done_o
);

  engine_state_e state_q;
  word_t         addr_q;
  len_t          issue_left_q;
  len_t          resp_left_q;
  logic          granted;

  assign wr_req_o   = (state_q == RUN) && not_empty_i;
  assign wr_addr_o  = addr_q;
  assign wr_wdata_o = pop_data_i;
  assign wr_be_o    = 4'hF;
  assign granted    = wr_req_o && wr_gnt_i;

  // Head word leaves the FIFO in the address phase
  assign pop_o = granted;

  // All writes issued; last response ends the copy
  assign xfer_done_o = (state_q == DRAIN) && wr_rvalid_i && (resp_left_q == len_t'(1));

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q <= IDLE;
    end else begin
      case (state_q)
        IDLE: begin
          if (start_i) begin
            state_q <= RUN;
          end
        end
        RUN: begin
          if (granted && (issue_left_q == len_t'(1))) begin
            state_q <= DRAIN;
          end
        end
        DRAIN: begin
          if (xfer_done_o) begin
            state_q <= IDLE;
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (start_i && (state_q == IDLE)) begin
      addr_q       <= dst_i;
      issue_left_q <= len_i;
      resp_left_q  <= len_i;
    end else begin
      if (granted) begin
        addr_q       <= addr_q + 32'd4;
        issue_left_q <= issue_left_q - len_t'(1);
      end
      if (wr_rvalid_i) begin
        resp_left_q <= resp_left_q - len_t'(1);
      end
    end
  end

endmodule

/* design/memcopy_top.sv */
// ========================================
// Memcopy DMA top level
// Register bus in, OBI read and write masters out, done interrupt
// ========================================

`timescale 1ns/1ps

module memcopy_top
  import memcopy_pkg::*;
#(
  parameter int unsigned fifo_depth = FIFO_DEPTH_DEFAULT
) (
  input  logic       clk_i,
  input  logic       reset_i,
  input  logic       reg_valid_i,
  input  logic       reg_write_i,
  input  word_t      reg_addr_i,
  input  word_t      reg_wdata_i,
  output logic       reg_ready_o,
  output word_t      reg_rdata_o,
  output logic       rd_req_o,
  output word_t      rd_addr_o,
  input  logic       rd_gnt_i,
  input  logic       rd_rvalid_i,
  input  word_t      rd_rdata_i,
  output logic       wr_req_o,
  output word_t      wr_addr_o,
  output word_t      wr_wdata_o,
  output logic [3:0] wr_be_o,
  input  logic       wr_gnt_i,
  input  logic       wr_rvalid_i,
  output logic       done_intr_o
);

  localparam int unsigned cnt_w = $clog2(fifo_depth + 1);

  logic             start;
  word_t            src;
  word_t            dst;
  len_t             len;
  logic             xfer_done;
  logic             push;
  word_t            push_data;
  logic             pop;
  word_t            pop_data;
  logic             not_empty;
  logic [cnt_w-1:0] free_count;

  memcopy_regs regs_i (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .reg_valid_i (reg_valid_i),
    .reg_write_i (reg_write_i),
    .reg_addr_i  (reg_addr_i),
    .reg_wdata_i (reg_wdata_i),
    .reg_ready_o (reg_ready_o),
    .reg_rdata_o (reg_rdata_o),
    .start_o     (start),
    .src_o       (src),
    .dst_o       (dst),
    .len_o       (len),
    .xfer_done_i (xfer_done),
    .done_intr_o (done_intr_o)
  );

  // Producer side
  obi_read_engine #(
    .fifo_depth(fifo_depth)
  ) rd_engine_i (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .start_i      (start),
    .src_i        (src),
    .len_i        (len),
    .free_count_i (free_count),
    .push_o       (push),
    .push_data_o  (push_data),
    .rd_req_o     (rd_req_o),
    .rd_addr_o    (rd_addr_o),
    .rd_gnt_i     (rd_gnt_i),
    .rd_rvalid_i  (rd_rvalid_i),
    .rd_rdata_i   (rd_rdata_i)
  );

  memcopy_fifo #(
    .fifo_depth(fifo_depth)
  ) fifo_i (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .push_i       (push),
    .push_data_i  (push_data),
    .pop_i        (pop),
    .pop_data_o   (pop_data),
    .not_empty_o  (not_empty),
    .free_count_o (free_count)
  );

  // Consumer side
  obi_write_engine wr_engine_i (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .start_i     (start),
    .dst_i       (dst),
    .len_i       (len),
    .not_empty_i (not_empty),
    .pop_data_i  (pop_data),
    .pop_o       (pop),
    .wr_req_o    (wr_req_o),
    .wr_addr_o   (wr_addr_o),
    .wr_wdata_o  (wr_wdata_o),
    .wr_be_o     (wr_be_o),
    .wr_gnt_i    (wr_gnt_i),
    .wr_rvalid_i (wr_rvalid_i),
    .xfer_done_o (xfer_done)
  );

endmodule

/* sim/tb_memcopy.sv */
// ========================================
// Directed testbench of the memcopy DMA
// Slow memory model behind both OBI ports, register bus tasks
// ========================================

`timescale 1ns/1ps

module tb_memcopy
  import memcopy_pkg::*;
;

  // Words copied over all tests times 8 cycles, plus generous margin
  localparam int TIMEOUT_CYCLES = 20000;
  localparam int MEM_WORDS      = 1024;

  logic       clk;
  logic       reset_i;
  logic       reg_valid;
  logic       reg_we;
  word_t      reg_addr;
  word_t      reg_wdata;
  logic       reg_ready;
  word_t      reg_rdata;
  logic       rd_req;
  word_t      rd_addr;
  logic       rd_gnt;
  logic       rd_rvalid;
  word_t      rd_rdata;
  logic       wr_req;
  word_t      wr_addr;
  word_t      wr_wdata;
  logic [3:0] wr_be;
  logic       wr_gnt;
  logic       wr_rvalid;
  logic       done_intr;

  integer seed = 32'he0efedf2;
  int     errors = 0;
  int     cycle = 0;
  word_t  mem [MEM_WORDS];
  word_t  status;

  // Slow memory bookkeeping
  int     rd_delay = -1;
  int     wr_delay = -1;
  int     rd_last_due = 0;
  int     wr_last_due = 0;
  int     due;
  word_t  rd_gaddr;
  word_t  wr_gaddr;
  word_t  wr_gdata;
  word_t  rd_data_q [$];
  int     rd_due_q [$];
  int     wr_due_q [$];
  int     inflight = 0;
  int     fifo_words = 0;
  int     max_inflight = 0;
  int     wr_count = 0;
  int     intr_cycles = 0;

  memcopy_top dut (
    .clk_i       (clk),
    .reset_i     (reset_i),
    .reg_valid_i (reg_valid),
    .reg_write_i (reg_we),
    .reg_addr_i  (reg_addr),
    .reg_wdata_i (reg_wdata),
    .reg_ready_o (reg_ready),
    .reg_rdata_o (reg_rdata),
    .rd_req_o    (rd_req),
    .rd_addr_o   (rd_addr),
    .rd_gnt_i    (rd_gnt),
    .rd_rvalid_i (rd_rvalid),
    .rd_rdata_i  (rd_rdata),
    .wr_req_o    (wr_req),
    .wr_addr_o   (wr_addr),
    .wr_wdata_o  (wr_wdata),
    .wr_be_o     (wr_be),
    .wr_gnt_i    (wr_gnt),
    .wr_rvalid_i (wr_rvalid),
    .done_intr_o (done_intr)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle++;
    if (cycle >= TIMEOUT_CYCLES) begin
      $display("Timeout: the copy never finished within %0d cycles", TIMEOUT_CYCLES);
      $display("TESTBENCH FAILED");
      $finish;
    end
  end

  // Reads in flight plus words waiting in the FIFO must fit the FIFO
  always @(negedge clk) begin
    if (done_intr) begin
      intr_cycles++;
    end
    if (inflight + fifo_words > max_inflight) begin
      max_inflight = inflight + fifo_words;
    end
  end

  function automatic int random_between(input int lo, input int hi);
    random_between = lo + int'($unsigned($random(seed)) % (hi - lo + 1));
  endfunction

  function automatic word_t fill_value(input word_t addr);
    fill_value = (addr * 32'h9E3779B1) ^ 32'hA5A50000 ^ addr;
  endfunction

  task automatic check_word(input word_t act, input word_t exp, input string what);
    if (act !== exp) begin
      errors++;
      $display("ERROR @ %0t: %s got %h expected %h", $time, what, act, exp);
    end
  endtask

  task automatic check_len(input len_t act, input len_t exp, input string what);
    if (act !== exp) begin
      errors++;
      $display("ERROR @ %0t: %s got %0d expected %0d", $time, what, act, exp);
    end
  endtask

  // Read port grants at random and answers in order 1 to 3 cycles later
  always @(posedge clk) begin
    #1;
    if (rd_rvalid) begin
      inflight--;
      fifo_words++;
    end
    if (rd_gnt) begin
      inflight++;
      due = cycle + random_between(1, 3) - 1;
      if (due <= rd_last_due) begin
        due = rd_last_due + 1;
      end
      rd_last_due = due;
      rd_data_q.push_back(mem[rd_gaddr[11:2]]);
      rd_due_q.push_back(due);
    end
    rd_gnt    = 1'b0;
    rd_rvalid = 1'b0;
    if (rd_due_q.size() > 0 && rd_due_q[0] <= cycle) begin
      rd_rvalid = 1'b1;
      rd_rdata  = rd_data_q.pop_front();
      void'(rd_due_q.pop_front());
    end
    if (rd_req) begin
      if (rd_delay < 0) begin
        rd_delay = random_between(0, 3);
      end
      if (rd_delay == 0) begin
        rd_gnt   = 1'b1;
        rd_gaddr = rd_addr;
        rd_delay = -1;
      end else begin
        rd_delay--;
      end
    end
  end

  // Write port updates memory in the address phase and responds later
  always @(posedge clk) begin
    #1;
    if (wr_gnt) begin
      mem[wr_gaddr[11:2]] = wr_gdata;
      wr_count++;
      fifo_words--;
      due = cycle + random_between(1, 3) - 1;
      if (due <= wr_last_due) begin
        due = wr_last_due + 1;
      end
      wr_last_due = due;
      wr_due_q.push_back(due);
    end
    wr_gnt    = 1'b0;
    wr_rvalid = 1'b0;
    if (wr_due_q.size() > 0 && wr_due_q[0] <= cycle) begin
      wr_rvalid = 1'b1;
      void'(wr_due_q.pop_front());
    end
    if (wr_req) begin
      if (wr_be !== 4'hF) begin
        errors++;
        $display("ERROR @ %0t: write byte enables are %b, not all ones", $time, wr_be);
      end
      if (wr_delay < 0) begin
        wr_delay = random_between(0, 3);
      end
      if (wr_delay == 0) begin
        wr_gnt   = 1'b1;
        wr_gaddr = wr_addr;
        wr_gdata = wr_wdata;
        wr_delay = -1;
      end else begin
        wr_delay--;
      end
    end
  end

  task automatic reg_access(input logic write, input word_t addr, input word_t data,
                            output word_t rdata);
    reg_valid = 1'b1;
    reg_we    = write;
    reg_addr  = addr;
    reg_wdata = data;
    do begin
      @(posedge clk);
      #1;
    end while (!reg_ready);
    rdata     = reg_rdata;
    reg_valid = 1'b0;
    reg_we    = 1'b0;
  endtask

  task automatic reg_write(input word_t addr, input word_t data);
    word_t unused;
    reg_access(1'b1, addr, data, unused);
  endtask

  task automatic reg_read(input word_t addr, output word_t data);
    reg_access(1'b0, addr, '0, data);
  endtask

  // Poll STATUS until done; the read that sees done also clears it
  task automatic wait_done(output word_t last_status);
    do begin
      reg_read(REG_STATUS, last_status);
    end while (!last_status[STATUS_DONE_BIT]);
  endtask

  task automatic init_mem();
    for (int i = 0; i < MEM_WORDS; i++) begin
      mem[i] = fill_value(word_t'(i * 4));
    end
  endtask

  task automatic start_copy(input word_t src, input word_t dst, input len_t len);
    reg_write(REG_SRC, src);
    reg_write(REG_DST, dst);
    reg_write(REG_LEN, {16'h0000, len});
  endtask

  task automatic verify_copy(input word_t src, input word_t dst, input len_t len);
    word_t addr;
    word_t exp;
    for (int i = 0; i < MEM_WORDS; i++) begin
      addr = word_t'(i * 4);
      if (addr >= dst && addr < dst + 4 * len) begin
        exp = fill_value(src + (addr - dst));
      end else begin
        exp = fill_value(addr);
      end
      check_word(mem[i], exp, $sformatf("mem[%h]", addr));
    end
  endtask

  task automatic test_registers();
    word_t data;
    check_word(word_t'({rd_req, wr_req, reg_ready, done_intr}), 32'h0,
               "request, ready and interrupt outputs after reset");
    reg_read(REG_STATUS, data);
    check_word(data, 32'h1, "STATUS after reset");
    reg_write(REG_SRC, 32'h0000_0140);
    reg_write(REG_DST, 32'h0000_0A80);
    reg_write(REG_INTR_EN, 32'h5A5A_A5A4);
    reg_read(REG_SRC, data);
    check_word(data, 32'h0000_0140, "SRC readback");
    reg_read(REG_DST, data);
    check_word(data, 32'h0000_0A80, "DST readback");
    reg_read(REG_INTR_EN, data);
    check_word(data, 32'h5A5A_A5A4, "INTR_EN readback");
  endtask

  task automatic test_basic_copy();
    init_mem();
    wr_count    = 0;
    reg_write(REG_INTR_EN, 32'h0);
    intr_cycles = 0;
    start_copy(32'h100, 32'h800, 16);
    wait_done(status);
    check_word(status, 32'h3, "STATUS at done");
    verify_copy(32'h100, 32'h800, 16);
    check_len(len_t'(wr_count), 16, "write count");
    check_word(word_t'(intr_cycles), 32'h0, "interrupt cycles while disabled");
  endtask

  task automatic test_interrupt();
    init_mem();
    reg_write(REG_INTR_EN, 32'h1);
    start_copy(32'h200, 32'hC00, 8);
    while (!done_intr) begin
      @(posedge clk);
      #1;
    end
    reg_read(REG_STATUS, status);
    check_word(status, 32'h3, "STATUS with interrupt");
    check_word(word_t'(done_intr), 32'h0, "interrupt after STATUS read");
    reg_read(REG_STATUS, status);
    check_word(status, 32'h1, "second STATUS read");
    verify_copy(32'h200, 32'hC00, 8);
    reg_write(REG_INTR_EN, 32'h0);
  endtask

  task automatic test_backpressure();
    init_mem();
    max_inflight = 0;
    start_copy(32'h040, 32'h600, 40);
    wait_done(status);
    verify_copy(32'h040, 32'h600, 40);
    if (max_inflight > FIFO_DEPTH_DEFAULT || max_inflight == 0) begin
      errors++;
      $display("Reads in flight plus words held peaked at %0d, outside 1 to %0d",
               max_inflight, FIFO_DEPTH_DEFAULT);
    end
  endtask

  task automatic test_ignored_len();
    init_mem();
    wr_count = 0;
    reg_write(REG_LEN, 32'h0);
    repeat (10) @(posedge clk);
    #1;
    reg_read(REG_STATUS, status);
    check_word(status, 32'h1, "STATUS after zero length");
    start_copy(32'h300, 32'hE00, 12);
    reg_read(REG_STATUS, status);
    check_word(status, 32'h0, "STATUS while busy");
    reg_write(REG_LEN, 32'h5);
    wait_done(status);
    verify_copy(32'h300, 32'hE00, 12);
    check_len(len_t'(wr_count), 12, "writes with ignored lengths");
  endtask

  initial begin
    reset_i   = 1'b1;
    reg_valid = 1'b0;
    reg_we    = 1'b0;
    reg_addr  = '0;
    reg_wdata = '0;
    rd_gnt    = 1'b0;
    rd_rvalid = 1'b0;
    rd_rdata  = '0;
    wr_gnt    = 1'b0;
    wr_rvalid = 1'b0;
    init_mem();
    repeat (16) @(posedge clk);
    #1;
    reset_i = 1'b0;
    @(posedge clk);
    #1;
    test_registers();
    test_basic_copy();
    test_interrupt();
    test_backpressure();
    test_ignored_len();
    $display("Run complete with %0d errors", errors);
    if (errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

/* flist.f */
design/memcopy_pkg.sv
design/memcopy_regs.sv
design/obi_read_engine.sv
design/memcopy_fifo.sv
design/obi_write_engine.sv
design/memcopy_top.sv
sim/tb_memcopy.sv

/* Bender.yml */
package:
  name: memcopy_dma

sources:
  - design/memcopy_pkg.sv
  - design/memcopy_regs.sv
  - design/obi_read_engine.sv
  - design/memcopy_fifo.sv
  - design/obi_write_engine.sv
  - design/memcopy_top.sv
  - target: simulation
    files:
      - sim/tb_memcopy.sv
